//--- files.f
src/matrix_pkg.sv
src/cmd_pkg.sv
src/cmd_queue.sv
src/glyph_render.sv
src/row_scanner.sv
src/matrix_display_top.sv
verification/clock_gen.sv
verification/matrix_display_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module matrix_display_tb -o matrix_display_sim

out=$(./obj_dir/matrix_display_sim) || true
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

//--- src/cmd_pkg.sv
// host command format for the display queue.
package cmd_pkg;

    // what a command puts on the matrix for one frame.
    typedef enum logic [1:0] {
        OP_BLANK = 2'd0,  // all dots off.
        OP_DIGIT = 2'd1,  // digit glyph.
        OP_FILL  = 2'd2   // all 64 dots on.
    } cmd_op_e;

    // decimal digit, only 0 to 9 are legal.
    typedef logic [3:0] digit_t;

    localparam digit_t DIGIT_MAX = 4'd9;

endpackage

//--- src/cmd_queue.sv
`timescale 1ns/1ns

// command FIFO on the host side. the host holds one credit per free slot
// and gets a credit back one cycle after each pop.
module cmd_queue
    import cmd_pkg::*, matrix_pkg::*;
#(
    parameter int FIFO_DEPTH = 4  // power of two.
)
(
    input  logic    clk,
    input  logic    rst,
    input  logic    cmd_valid,
    input  cmd_op_e cmd_op,
    input  digit_t  cmd_digit,
    input  color_e  cmd_color,
    input  logic    pop,
    output logic    cmd_credit,
    output logic    head_valid,
    output cmd_op_e head_op,
    output digit_t  head_digit,
    output color_e  head_color
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    cmd_op_e op_mem    [FIFO_DEPTH];
    digit_t  digit_mem [FIFO_DEPTH];
    color_e  color_mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;

    assign full       = (count == CNT_W'(FIFO_DEPTH));
    assign head_valid = (count != '0);

    // head entry is visible as soon as it is written.
    assign head_op    = op_mem[rd_ptr];
    assign head_digit = digit_mem[rd_ptr];
    assign head_color = color_mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (cmd_valid)
        begin
            op_mem[wr_ptr]    <= cmd_op;
            digit_mem[wr_ptr] <= cmd_digit;
            color_mem[wr_ptr] <= cmd_color;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            cmd_credit <= 1'b0;
        end
        else
        begin
            if (cmd_valid)
                wr_ptr <= wr_ptr + PTR_W'(1);  // wraps, depth is 2**n.
            if (pop)
                rd_ptr <= rd_ptr + PTR_W'(1);

            case ({cmd_valid, pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase

            cmd_credit <= pop;  // slot freed, hand it back.
        end
    end

    // host spent a credit it did not have.
    a_no_overrun: assert property (@(posedge clk) disable iff (rst)
        cmd_valid |-> !full)
        else $error("cmd_queue: command written while queue full");

    a_no_underrun: assert property (@(posedge clk) disable iff (rst)
        pop |-> head_valid)
        else $error("cmd_queue: pop from empty queue");

    a_digit_range: assert property (@(posedge clk) disable iff (rst)
        (cmd_valid && cmd_op == OP_DIGIT) |-> cmd_digit <= DIGIT_MAX)
        else $error("cmd_queue: digit %0d out of range", cmd_digit);

endmodule

//--- src/glyph_render.sv
`timescale 1ns/1ns

// takes one command per frame and turns it into column patterns for the
// red and green planes, one row at a time.
module glyph_render
    import cmd_pkg::*, matrix_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     frame_start,
    input  row_idx_t row_num,
    input  logic     head_valid,
    input  cmd_op_e  head_op,
    input  digit_t   head_digit,
    input  color_e   head_color,
    output logic     pop,
    output col_t     col_red,
    output col_t     col_green
);

    // 6 dots wide, 7 rows tall, row 0 left dark.
    function automatic col_t glyph_row(input digit_t d, input row_idx_t r);
        col_t rows [N_ROWS];
        begin
            case (d)
                4'd0:    rows = '{8'h00, 8'h3c, 8'h66, 8'h6e, 8'h76, 8'h66, 8'h66, 8'h3c};
                4'd1:    rows = '{8'h00, 8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h18, 8'h7e};
                4'd2:    rows = '{8'h00, 8'h3c, 8'h66, 8'h06, 8'h0c, 8'h30, 8'h66, 8'h3c};
                4'd3:    rows = '{8'h00, 8'h3c, 8'h66, 8'h06, 8'h1c, 8'h06, 8'h66, 8'h3c};
                4'd4:    rows = '{8'h00, 8'h0c, 8'h1c, 8'h2c, 8'h4c, 8'h7e, 8'h0c, 8'h0c};
                4'd5:    rows = '{8'h00, 8'h7e, 8'h60, 8'h7c, 8'h06, 8'h06, 8'h66, 8'h3c};
                4'd6:    rows = '{8'h00, 8'h3c, 8'h60, 8'h7c, 8'h66, 8'h66, 8'h66, 8'h3c};
                4'd7:    rows = '{8'h00, 8'h7e, 8'h06, 8'h0c, 8'h18, 8'h18, 8'h18, 8'h18};
                4'd8:    rows = '{8'h00, 8'h3c, 8'h66, 8'h66, 8'h3c, 8'h66, 8'h66, 8'h3c};
                4'd9:    rows = '{8'h00, 8'h3c, 8'h66, 8'h66, 8'h3e, 8'h06, 8'h66, 8'h3c};
                default: rows = '{default: 8'h00};
            endcase
            return rows[r];
        end
    endfunction

    // image shown for the current frame.
    cmd_op_e img_op;
    digit_t  img_digit;
    color_e  img_color;

    cmd_op_e sel_op;
    digit_t  sel_digit;
    color_e  sel_color;
    col_t    pattern;
    logic    red_on;
    logic    green_on;

    // pop only at a frame boundary, so one command fills a whole frame.
    assign pop = frame_start && head_valid;

    // row 0 of a new frame already uses the command being popped.
    assign sel_op    = pop ? head_op    : img_op;
    assign sel_digit = pop ? head_digit : img_digit;
    assign sel_color = pop ? head_color : img_color;

    always_comb
    begin
        case (sel_op)
            OP_DIGIT: pattern = glyph_row(sel_digit, row_num);
            OP_FILL:  pattern = '1;
            default:  pattern = '0;
        endcase
    end

    assign red_on   = (sel_color == COLOR_RED)   || (sel_color == COLOR_YELLOW);
    assign green_on = (sel_color == COLOR_GREEN) || (sel_color == COLOR_YELLOW);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            img_op    <= OP_BLANK;  // dark until the first command.
            img_digit <= '0;
            img_color <= COLOR_RED;
        end
        else if (pop)
        begin
            img_op    <= head_op;
            img_digit <= head_digit;
            img_color <= head_color;
        end
    end

    // one cycle behind row_num, same as the row drive.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            col_red   <= '0;
            col_green <= '0;
        end
        else
        begin
            col_red   <= red_on   ? pattern : '0;
            col_green <= green_on ? pattern : '0;
        end
    end

    // scanner must mark frames on row 0 only.
    a_pop_on_frame: assert property (@(posedge clk) disable iff (rst)
        frame_start |-> (row_num == '0))
        else $error("glyph_render: frame start away from row 0");

endmodule

//--- src/matrix_display_top.sv
`timescale 1ns/1ns

// dot matrix countdown display: command queue, glyph renderer, row scanner.
module matrix_display_top
    import cmd_pkg::*, matrix_pkg::*;
#(
    parameter int FIFO_DEPTH = 4,
    parameter int ROW_CYCLES = 4
)
(
    input  logic              clk,
    input  logic              rst,
    input  logic              cmd_valid,
    input  cmd_op_e           cmd_op,
    input  digit_t            cmd_digit,
    input  color_e            cmd_color,
    output logic              cmd_credit,
    output logic [N_ROWS-1:0] row,
    output col_t              col_red,
    output col_t              col_green
);

    logic     head_valid;
    cmd_op_e  head_op;
    digit_t   head_digit;
    color_e   head_color;
    logic     pop;
    row_idx_t row_num;
    logic     frame_start;

    cmd_queue #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_cmd_queue (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_digit  (cmd_digit),
        .cmd_color  (cmd_color),
        .pop        (pop),
        .cmd_credit (cmd_credit),
        .head_valid (head_valid),
        .head_op    (head_op),
        .head_digit (head_digit),
        .head_color (head_color)
    );

    glyph_render u_glyph_render (
        .clk         (clk),
        .rst         (rst),
        .frame_start (frame_start),
        .row_num     (row_num),
        .head_valid  (head_valid),
        .head_op     (head_op),
        .head_digit  (head_digit),
        .head_color  (head_color),
        .pop         (pop),
        .col_red     (col_red),
        .col_green   (col_green)
    );

    row_scanner #(
        .ROW_CYCLES (ROW_CYCLES)
    ) u_row_scanner (
        .clk         (clk),
        .rst         (rst),
        .row_num     (row_num),
        .frame_start (frame_start),
        .row         (row)
    );

endmodule

//--- src/matrix_pkg.sv
// geometry and colours of the 8x8 red/green dot matrix.
package matrix_pkg;

    // glyph shapes are drawn for exactly this many rows.
    localparam int N_ROWS = 8;

    // row number within one scan frame.
    typedef logic [2:0] row_idx_t;

    // column pattern of one colour plane, bit 7 is the leftmost dot.
    typedef logic [7:0] col_t;

    // display colour of a whole frame.
    typedef enum logic [1:0] {
        COLOR_RED    = 2'd0,
        COLOR_GREEN  = 2'd1,
        COLOR_YELLOW = 2'd2  // red and green planes together.
    } color_e;

endpackage

//--- src/row_scanner.sv
`timescale 1ns/1ns

// steps through the rows, ROW_CYCLES clocks each, and drives the one-hot
// row lines.
module row_scanner
    import matrix_pkg::*;
#(
    parameter int ROW_CYCLES = 4  // at least 2.
)
(
    input  logic              clk,
    input  logic              rst,
    output row_idx_t          row_num,
    output logic              frame_start,
    output logic [N_ROWS-1:0] row
);

    localparam int CNT_W = $clog2(ROW_CYCLES);

    logic [CNT_W-1:0] dwell_cnt;
    logic             row_done;

    assign row_done    = (dwell_cnt == CNT_W'(ROW_CYCLES - 1));
    assign frame_start = (row_num == '0) && (dwell_cnt == '0);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            dwell_cnt <= '0;
            row_num   <= '0;
        end
        else if (row_done)
        begin
            dwell_cnt <= '0;
            row_num   <= row_num + 3'd1;  // 7 wraps to 0.
        end
        else
            dwell_cnt <= dwell_cnt + CNT_W'(1);
    end

    // registered so it lines up with the column outputs.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            row <= '0;
        else
            row <= {{(N_ROWS - 1){1'b0}}, 1'b1} << row_num;
    end

    a_row_onehot: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> $onehot(row))
        else $error("row_scanner: row drive not one-hot: %b", row);

endmodule

//--- verification/clock_gen.sv
`timescale 1ns/1ns

// free running clock and a reset held for a fixed number of cycles.
module clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 16,
    parameter int RELEASE_NS   = 2
)
(
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD_NS / 2) clk = ~clk;
    end

    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #RELEASE_NS rst = 1'b0;  // released just after an edge.
    end

endmodule

//--- verification/matrix_display_tb.sv
`timescale 1ns/1ns

// drives display commands under the credit rule and checks every scanned
// frame against its own glyph table.
module matrix_display_tb
    import cmd_pkg::*, matrix_pkg::*;
();

    localparam int FIFO_DEPTH   = 4;
    localparam int ROW_CYCLES   = 4;
    localparam int CLK_NS       = 40;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY  = 2;
    localparam int N_CMDS       = 16;
    localparam int FRONT_LOAD   = 8;  // sent as fast as credits allow.
    localparam int MAX_GAP      = 40;
    localparam int FRAME_CYCLES = N_ROWS * ROW_CYCLES;
    localparam int SAMPLE_AT    = ROW_CYCLES / 2;
    localparam int WATCHDOG_NS  = (N_CMDS + 4) * FRAME_CYCLES * CLK_NS
                                + (RESET_CYCLES + N_CMDS * MAX_GAP + 4 * FRAME_CYCLES) * CLK_NS;

    // test ids for the error counters.
    localparam int T_RESET  = 0;
    localparam int T_DIGIT  = 1;
    localparam int T_OPCODE = 2;
    localparam int T_CREDIT = 3;
    localparam int T_HOLD   = 4;
    localparam int T_SCAN   = 5;

    logic              clk;
    logic              rst;
    logic              cmd_valid;
    cmd_op_e           cmd_op;
    digit_t            cmd_digit;
    color_e            cmd_color;
    logic              cmd_credit;
    logic [N_ROWS-1:0] row;
    col_t              col_red;
    col_t              col_green;

    // command table. every digit, every colour, blank and fill.
    cmd_op_e tbl_op [N_CMDS] = '{
        OP_DIGIT, OP_DIGIT, OP_DIGIT, OP_DIGIT, OP_DIGIT, OP_DIGIT, OP_BLANK, OP_FILL,
        OP_FILL,  OP_FILL,  OP_DIGIT, OP_DIGIT, OP_DIGIT, OP_DIGIT, OP_BLANK, OP_DIGIT
    };
    digit_t tbl_digit [N_CMDS] = '{
        4'd5, 4'd4, 4'd3, 4'd2, 4'd0, 4'd1, 4'd0, 4'd0,
        4'd0, 4'd0, 4'd6, 4'd7, 4'd8, 4'd9, 4'd0, 4'd5
    };
    color_e tbl_color [N_CMDS] = '{
        COLOR_RED,    COLOR_GREEN,  COLOR_YELLOW, COLOR_RED,
        COLOR_GREEN,  COLOR_YELLOW, COLOR_YELLOW, COLOR_RED,
        COLOR_GREEN,  COLOR_YELLOW, COLOR_RED,    COLOR_GREEN,
        COLOR_YELLOW, COLOR_RED,    COLOR_GREEN,  COLOR_YELLOW
    };

    // digit glyphs, row 0 in the top byte.
    logic [63:0] glyph_bits [10] = '{
        64'h003c_666e_7666_663c, 64'h0018_3818_1818_187e,
        64'h003c_6606_0c30_663c, 64'h003c_6606_1c06_663c,
        64'h000c_1c2c_4c7e_0c0c, 64'h007e_607c_0606_663c,
        64'h003c_607c_6666_663c, 64'h007e_060c_1818_1818,
        64'h003c_6666_3c66_663c, 64'h003c_6666_3e06_663c
    };

    int                err_by_test [6] = '{default: 0};
    int                sent_cnt        = 0;
    int                written_cnt     = 0;
    int                written_before  = 0;
    int                credit_cnt      = 0;
    int                pop_cnt         = 0;
    int                frames_done     = 0;
    int                hold_cnt        = 0;
    int                shown_idx       = -1;  // blank until the first pop.
    int                tests_passed    = 0;
    int                tests_failed    = 0;
    int                dwell_len       = 0;
    int                row_pos         = 0;
    logic              frame_repeat    = 1'b0;
    logic [N_ROWS-1:0] prev_row        = '0;
    logic [31:0]       lcg_state       = 32'hd49d_ec1c;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // one row before the colour is applied.
    function automatic col_t expected_pattern(input cmd_op_e op, input digit_t d, input int r);
        case (op)
            OP_DIGIT: return glyph_bits[int'(d)][63 - 8 * r -: 8];
            OP_FILL:  return 8'hff;
            default:  return 8'h00;
        endcase
    endfunction

    function automatic logic lights_red(input color_e c);
        return (c == COLOR_RED) || (c == COLOR_YELLOW);
    endfunction

    function automatic logic lights_green(input color_e c);
        return (c == COLOR_GREEN) || (c == COLOR_YELLOW);
    endfunction

    function automatic int total_errors();
        int sum;
        sum = 0;
        for (int t = 0; t < 6; t++)
            sum += err_by_test[t];
        return sum;
    endfunction

    task automatic report_test(input string name, input int test_id);
        if (err_by_test[test_id] == 0)
        begin
            tests_passed++;
            $display("[pass] %s", name);
        end
        else
        begin
            tests_failed++;
            $display("[fail] %s, %0d errors", name, err_by_test[test_id]);
        end
    endtask

    // outputs held at zero in reset.
    task automatic check_idle(input string name, input logic [7:0] value);
        if (value !== '0)
        begin
            $display("CHECK FAILED %s during reset: expected 00, got %h", name, value);
            err_by_test[T_RESET]++;
        end
    endtask

    task automatic idle_cycle();
        cmd_valid = 1'b0;
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // waits for a credit, then presents one table entry for one cycle.
    task automatic send_cmd(input int idx);
        while (sent_cnt - credit_cnt >= FIFO_DEPTH)
            idle_cycle();
        cmd_valid = 1'b1;
        cmd_op    = tbl_op[idx];
        cmd_digit = tbl_digit[idx];
        cmd_color = tbl_color[idx];
        sent_cnt++;
        @(posedge clk);
        #DRIVE_DELAY;
        cmd_valid = 1'b0;
    endtask

    clock_gen #(
        .PERIOD_NS    (CLK_NS),
        .RESET_CYCLES (RESET_CYCLES),
        .RELEASE_NS   (DRIVE_DELAY)
    ) u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    matrix_display_top #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .ROW_CYCLES (ROW_CYCLES)
    ) DUT (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_digit  (cmd_digit),
        .cmd_color  (cmd_color),
        .cmd_credit (cmd_credit),
        .row        (row),
        .col_red    (col_red),
        .col_green  (col_green)
    );

    // commands taken by the queue before the latest edge.
    always @(posedge clk)
    begin
        written_before = written_cnt;
        if (cmd_valid)
            written_cnt++;
    end

    always @(negedge clk)
    begin : monitor
        logic [N_ROWS-1:0] next_row;
        logic              exp_credit;
        col_t              pattern;
        col_t              exp_red;
        col_t              exp_green;
        int                test_id;
        if (rst)
        begin
            check_idle("row", row);
            check_idle("col_red", col_red);
            check_idle("col_green", col_green);
            check_idle("cmd_credit", {7'b0, cmd_credit});
            prev_row  = '0;
            dwell_len = 0;
        end
        else
        begin
            exp_credit = 1'b0;
            if (row !== prev_row)
            begin
                if (prev_row != '0 && dwell_len != ROW_CYCLES)
                begin
                    $display("row %0d stayed lit for %0d cycles instead of %0d",
                             row_pos, dwell_len, ROW_CYCLES);
                    err_by_test[T_SCAN]++;
                end
                next_row = (prev_row == '0 || prev_row[N_ROWS-1]) ? N_ROWS'(1) : prev_row << 1;
                if (row !== next_row)
                begin
                    $display("CHECK FAILED row: expected %h, got %h", next_row, row);
                    err_by_test[T_SCAN]++;
                end
                dwell_len = 1;
                if (row == N_ROWS'(1))
                begin
                    // the edge that lit row 0 is the pop edge.
                    row_pos      = 0;
                    frame_repeat = (written_before <= shown_idx + 1);
                    if (!frame_repeat)
                    begin
                        shown_idx++;
                        pop_cnt++;
                        exp_credit = 1'b1;
                    end
                end
                else
                    row_pos++;
                prev_row = row;
            end
            else
                dwell_len++;

            if (cmd_credit !== exp_credit)
            begin
                $display("CHECK FAILED cmd_credit: expected %h, got %h", exp_credit, cmd_credit);
                err_by_test[T_CREDIT]++;
            end
            if (cmd_credit === 1'b1)
                credit_cnt++;
            if (credit_cnt > sent_cnt)
            begin
                $display("credit count out of range: %0d sent, %0d returned",
                         sent_cnt, credit_cnt);
                err_by_test[T_CREDIT]++;
            end

            if (prev_row != '0 && dwell_len == SAMPLE_AT)  // middle of the dwell.
            begin
                if (shown_idx < 0)
                begin
                    exp_red   = '0;
                    exp_green = '0;
                    test_id   = T_RESET;
                end
                else
                begin
                    pattern   = expected_pattern(tbl_op[shown_idx], tbl_digit[shown_idx],
                                                 row_pos);
                    exp_red   = lights_red(tbl_color[shown_idx]) ? pattern : '0;
                    exp_green = lights_green(tbl_color[shown_idx]) ? pattern : '0;
                    if (frame_repeat && shown_idx == N_CMDS - 1)
                        test_id = T_HOLD;
                    else if (tbl_op[shown_idx] == OP_DIGIT)
                        test_id = T_DIGIT;
                    else
                        test_id = T_OPCODE;
                end
                if (col_red !== exp_red)
                begin
                    $display("CHECK FAILED col_red row %0d: expected %h, got %h",
                             row_pos, exp_red, col_red);
                    err_by_test[test_id]++;
                end
                if (col_green !== exp_green)
                begin
                    $display("CHECK FAILED col_green row %0d: expected %h, got %h",
                             row_pos, exp_green, col_green);
                    err_by_test[test_id]++;
                end
                if (row_pos == N_ROWS - 1)
                begin
                    frames_done++;
                    if (shown_idx == N_CMDS - 1)
                        hold_cnt++;
                end
            end
        end
    end

    initial
    begin : stimulus
        int gap;
        cmd_valid = 1'b0;
        cmd_op    = OP_BLANK;
        cmd_digit = '0;
        cmd_color = COLOR_RED;
        @(negedge rst);
        wait (frames_done >= 1);  // one dark frame first.
        report_test("reset state", T_RESET);
        idle_cycle();
        for (int i = 0; i < N_CMDS; i++)
        begin
            if (i >= FRONT_LOAD)
            begin
                gap = int'((next_rand() >> 16) % 32'(MAX_GAP + 1));
                repeat (gap) idle_cycle();
            end
            send_cmd(i);
        end
        wait (hold_cnt >= 1);
        report_test("digit glyphs in each colour", T_DIGIT);
        report_test("blank and fill opcodes", T_OPCODE);
        report_test("row scan", T_SCAN);
        wait (hold_cnt >= 3);  // last image and two repeats.
        if (sent_cnt != N_CMDS || credit_cnt != N_CMDS || pop_cnt != N_CMDS)
        begin
            $display("credits not all back: %0d sent, %0d shown, %0d credits returned",
                     sent_cnt, pop_cnt, credit_cnt);
            err_by_test[T_CREDIT]++;
        end
        report_test("credit flow under back-pressure", T_CREDIT);
        report_test("hold when idle", T_HOLD);
        $display("tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, total_errors());
        if (tests_failed == 0 && total_errors() == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    initial
    begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule
